// ==== verilog/svm_dot_defines.svh ====
`ifndef SVM_DOT_DEFINES_SVH
`define SVM_DOT_DEFINES_SVH

// lane count is also the longest vector the core takes
`define SVM_NUM_LANES  8

`define SVM_DATA_W     16  // one vector element.
`define SVM_PROD_W     32  // full 16x16 signed product.

// log2 of the lane count
`define SVM_TREE_DEPTH 3

`define SVM_SUM_W      35  // product width plus one bit per tree level.
`define SVM_DIM_W      4   // must hold the lane count itself.

`endif

// ==== verilog/svm_dot_pkg.sv ====
`include "svm_dot_defines.svh"

package svm_dot_pkg;

   typedef logic signed [`SVM_DATA_W-1:0] data_t;
   typedef logic signed [`SVM_PROD_W-1:0] prod_t;
   typedef logic signed [`SVM_SUM_W-1:0]  sum_t;
   typedef logic [`SVM_DIM_W-1:0]         dim_t;  // number of active elements.

   // element i sits at index i
   typedef data_t [`SVM_NUM_LANES-1:0] vec_t;
   typedef prod_t [`SVM_NUM_LANES-1:0] prod_vec_t;

endpackage

// ==== verilog/svm_vec_if.sv ====
`timescale 1ns/100ps

interface svm_vec_if;

   svm_dot_pkg::vec_t weight_vec;
   svm_dot_pkg::vec_t data_vec;
   logic              weights_progd;   // weight array complete.
   logic              data_vec_progd;  // data array complete.

   modport loader (
      output weight_vec,
      output data_vec,
      output weights_progd,
      output data_vec_progd
   );

   modport lane (
      input weight_vec,
      input data_vec,
      input weights_progd,
      input data_vec_progd
   );

endinterface

// ==== verilog/svm_vec_loader.sv ====
`timescale 1ns/100ps
`include "svm_dot_defines.svh"

module svm_vec_loader (
   input  logic                clk,
   input  logic                reset,
   input  svm_dot_pkg::data_t  mem_mngr_data,
   input  logic                mem_mngr_data_vld,
   input  logic                arr_wghtbar_data,
   input  svm_dot_pkg::dim_t   svm_ctrl_part_num_dim,
   input  logic                clear_weights_n_data,
   svm_vec_if.loader           vec
);

   import svm_dot_pkg::*;

   // index 0 holds the weights, index 1 the data vector
   vec_t       arr [2];
   dim_t       cnt [2];
   logic [1:0] progd;

   logic                       sel;
   dim_t                       cur_cnt;
   dim_t                       nxt_cnt;
   logic [`SVM_TREE_DEPTH-1:0] wr_idx;
   logic                       take;

   assign sel     = arr_wghtbar_data;
   assign cur_cnt = cnt[sel];
   assign nxt_cnt = cur_cnt + dim_t'(1);
   assign wr_idx  = cur_cnt[`SVM_TREE_DEPTH-1:0];  // below lane count while loading.
   assign take    = mem_mngr_data_vld && !progd[sel];  // full array drops extras.

   always_ff @(posedge clk) begin
      if (reset || clear_weights_n_data) begin
         for (int t = 0; t < 2; t++) begin
            arr[t] <= '0;  // unused elements must read as zero.
            cnt[t] <= '0;
         end
         progd <= '0;
      end else if (take) begin
         arr[sel][wr_idx] <= mem_mngr_data;
         cnt[sel]         <= nxt_cnt;
         if (nxt_cnt == svm_ctrl_part_num_dim) begin
            progd[sel] <= 1'b1;  // last word of this vector.
         end
      end
   end

   assign vec.weight_vec     = arr[0];
   assign vec.data_vec       = arr[1];
   assign vec.weights_progd  = progd[0];
   assign vec.data_vec_progd = progd[1];

endmodule

// ==== verilog/svm_mult_lane.sv ====
`timescale 1ns/100ps

module svm_mult_lane #(
   parameter int LANE_IDX = 0
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                comp_start,
   svm_vec_if.lane             vec,
   output svm_dot_pkg::prod_t  prod,
   output logic                prod_vld
);

   import svm_dot_pkg::*;

   logic  launch;
   data_t wght_q;
   data_t data_q;
   logic  op_vld;

   // both vectors must be complete before a start counts
   assign launch = comp_start & vec.weights_progd & vec.data_vec_progd;

   always_ff @(posedge clk) begin
      if (launch) begin
         wght_q <= vec.weight_vec[LANE_IDX];
         data_q <= vec.data_vec[LANE_IDX];
      end
   end

   always_ff @(posedge clk) begin
      if (op_vld) begin
         prod <= prod_t'(wght_q) * prod_t'(data_q);  // exact, no rounding.
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         op_vld   <= 1'b0;
         prod_vld <= 1'b0;
      end else begin
         op_vld   <= launch;
         prod_vld <= op_vld;
      end
   end

endmodule

// ==== verilog/svm_adder_tree.sv ====
`timescale 1ns/100ps
`include "svm_dot_defines.svh"

module svm_adder_tree (
   input  logic                    clk,
   input  logic                    reset,
   input  svm_dot_pkg::prod_vec_t  prods,
   input  logic                    in_vld,
   output svm_dot_pkg::sum_t       data_out,
   output logic                    data_out_vld
);

   import svm_dot_pkg::*;

   localparam int N = `SVM_NUM_LANES;
   localparam int D = `SVM_TREE_DEPTH;

   logic [D-1:0] vld_q;  // bit l marks a fresh sum in level l.

   always_ff @(posedge clk) begin
      if (reset) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[D-2:0], in_vld};
      end
   end

   for (genvar l = 0; l < D; l++) begin : lvl
      localparam int NODES = N >> (l + 1);
      localparam int W     = `SVM_PROD_W + l + 1;

      logic en;

      if (l == 0) begin : g_first
         assign en = in_vld;
      end else begin : g_next
         assign en = vld_q[l-1];
      end

      for (genvar n = 0; n < NODES; n++) begin : node
         logic signed [W-2:0] a;
         logic signed [W-2:0] b;
         logic signed [W-1:0] sum;

         if (l == 0) begin : g_leaf
            assign a = prods[2*n];
            assign b = prods[2*n+1];
         end else begin : g_inner
            assign a = lvl[l-1].node[2*n].sum;
            assign b = lvl[l-1].node[2*n+1].sum;
         end

         // sign-extend one bit so the pair sum cannot overflow
         always_ff @(posedge clk) begin
            if (reset) begin
               sum <= '0;
            end else if (en) begin
               sum <= {a[W-2], a} + {b[W-2], b};
            end
         end
      end
   end

   assign data_out     = lvl[D-1].node[0].sum;  // root holds the dot product.
   assign data_out_vld = vld_q[D-1];

endmodule

// ==== verilog/svm_dot_core.sv ====
`timescale 1ns/100ps
`include "svm_dot_defines.svh"

module svm_dot_core (
   input  logic                clk,
   input  logic                reset,
   input  svm_dot_pkg::data_t  mem_mngr_data,
   input  logic                mem_mngr_data_vld,
   input  svm_dot_pkg::dim_t   svm_ctrl_part_num_dim,
   input  logic                comp_start,
   input  logic                arr_wghtbar_data,
   input  logic                clear_weights_n_data,
   output svm_dot_pkg::sum_t   data_out,
   output logic                data_out_vld,
   output logic                weights_progd,
   output logic                data_vec_progd
);

   import svm_dot_pkg::*;

   prod_vec_t lane_prods;
   logic      prod_vld;  // all lanes run in lockstep.

   svm_vec_if vec_bus ();

   svm_vec_loader u_loader (
      .clk                   (clk),
      .reset                 (reset),
      .mem_mngr_data         (mem_mngr_data),
      .mem_mngr_data_vld     (mem_mngr_data_vld),
      .arr_wghtbar_data      (arr_wghtbar_data),
      .svm_ctrl_part_num_dim (svm_ctrl_part_num_dim),
      .clear_weights_n_data  (clear_weights_n_data),
      .vec                   (vec_bus.loader)
   );

   for (genvar i = 0; i < `SVM_NUM_LANES; i++) begin : g_lane
      if (i == 0) begin : g_head
         svm_mult_lane #(.LANE_IDX(i)) u_lane (
            .clk        (clk),
            .reset      (reset),
            .comp_start (comp_start),
            .vec        (vec_bus.lane),
            .prod       (lane_prods[i]),
            .prod_vld   (prod_vld)
         );
      end else begin : g_rest
         svm_mult_lane #(.LANE_IDX(i)) u_lane (
            .clk        (clk),
            .reset      (reset),
            .comp_start (comp_start),
            .vec        (vec_bus.lane),
            .prod       (lane_prods[i]),
            .prod_vld   ()
         );
      end
   end

   svm_adder_tree u_tree (
      .clk          (clk),
      .reset        (reset),
      .prods        (lane_prods),
      .in_vld       (prod_vld),
      .data_out     (data_out),
      .data_out_vld (data_out_vld)
   );

   assign weights_progd  = vec_bus.weights_progd;
   assign data_vec_progd = vec_bus.data_vec_progd;

endmodule

// ==== verification/svm_dot_core_props.sv ====
`timescale 1ns/100ps

module svm_dot_core_props (
   input logic clk,
   input logic reset,
   input logic comp_start,
   input logic clear_weights_n_data,
   input logic weights_progd,
   input logic data_vec_progd,
   input logic data_out_vld
);

   logic launch;
   int   err_count = 0;  // failed assertions so far.

   assign launch = comp_start && weights_progd && data_vec_progd;

   property p_flags_low_after_reset;
      @(posedge clk) reset |=> (!weights_progd && !data_vec_progd);
   endproperty

   // a programmed vector stays programmed until cleared
   property p_weights_hold;
      @(posedge clk) disable iff (reset)
         (weights_progd && !clear_weights_n_data) |=> weights_progd;
   endproperty

   property p_data_hold;
      @(posedge clk) disable iff (reset)
         (data_vec_progd && !clear_weights_n_data) |=> data_vec_progd;
   endproperty

   property p_result_after_launch;
      @(posedge clk) disable iff (reset) $past(launch, 5) |-> data_out_vld;
   endproperty

   property p_no_result_without_launch;
      @(posedge clk) disable iff (reset) data_out_vld |-> $past(launch, 5);
   endproperty

   a_flags_low_after_reset : assert property (p_flags_low_after_reset) else begin
      err_count++;
      $error("programmed flag high right after reset");
   end
   a_weights_hold : assert property (p_weights_hold) else begin
      err_count++;
      $error("weights_progd dropped without a clear");
   end
   a_data_hold : assert property (p_data_hold) else begin
      err_count++;
      $error("data_vec_progd dropped without a clear");
   end
   a_result_after_launch : assert property (p_result_after_launch) else begin
      err_count++;
      $error("no data_out_vld five cycles after a launch");
   end
   a_no_result_without_launch : assert property (p_no_result_without_launch) else begin
      err_count++;
      $error("data_out_vld without a launch five cycles before");
   end

endmodule

bind svm_dot_core svm_dot_core_props u_props (.*);

// ==== verification/svm_dot_core_tb.sv ====
`timescale 1ns/100ps
`include "svm_dot_defines.svh"

module svm_dot_core_tb;

   import svm_dot_pkg::*;

   localparam int NUM_LANES    = `SVM_NUM_LANES;
   localparam int CLK_PERIOD   = 20;
   localparam int NUM_ROUNDS   = 40;
   localparam int ROUND_CYCLES = 80;
   localparam int WATCHDOG_NS  = NUM_ROUNDS * ROUND_CYCLES * CLK_PERIOD + 2000;
   localparam int LATENCY      = 5;  // launch drive to result, in cycles.

   logic  clk;
   logic  reset;
   data_t mem_mngr_data;
   logic  mem_mngr_data_vld;
   dim_t  svm_ctrl_part_num_dim;
   logic  comp_start;
   logic  arr_wghtbar_data;
   logic  clear_weights_n_data;
   sum_t  data_out;
   logic  data_out_vld;
   logic  weights_progd;
   logic  data_vec_progd;

   int seed = 67;
   int cyc  = 0;

   // reference model state, index 0 weights, index 1 data
   int   mdl_vec [2][NUM_LANES];
   int   mdl_cnt [2];
   bit   mdl_progd [2];
   int   mdl_dim;
   sum_t exp_sum [$];
   int   exp_due [$];

   svm_dot_core dut (
      .clk                   (clk),
      .reset                 (reset),
      .mem_mngr_data         (mem_mngr_data),
      .mem_mngr_data_vld     (mem_mngr_data_vld),
      .svm_ctrl_part_num_dim (svm_ctrl_part_num_dim),
      .comp_start            (comp_start),
      .arr_wghtbar_data      (arr_wghtbar_data),
      .clear_weights_n_data  (clear_weights_n_data),
      .data_out              (data_out),
      .data_out_vld          (data_out_vld),
      .weights_progd         (weights_progd),
      .data_vec_progd        (data_vec_progd)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
   endtask

   function automatic int pick_range(input int lo, input int hi);
      pick_range = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   function automatic data_t random_word();
      random_word = data_t'($random(seed));
   endfunction

   task automatic wipe_model();
      for (int t = 0; t < 2; t++) begin
         for (int i = 0; i < NUM_LANES; i++) begin
            mdl_vec[t][i] = 0;
         end
         mdl_cnt[t]   = 0;
         mdl_progd[t] = 1'b0;
      end
   endtask

   task automatic store_word(input logic target, input data_t word);
      int t;
      t = target ? 1 : 0;
      if (!mdl_progd[t]) begin  // full array ignores extras.
         mdl_vec[t][mdl_cnt[t]] = int'(word);
         mdl_cnt[t]++;
         if (mdl_cnt[t] == mdl_dim) begin
            mdl_progd[t] = 1'b1;
         end
      end
   endtask

   function automatic sum_t expected_dot();
      longint acc;
      acc = 0;
      for (int i = 0; i < mdl_dim; i++) begin
         acc += longint'(mdl_vec[0][i]) * longint'(mdl_vec[1][i]);
      end
      expected_dot = sum_t'(acc);
   endfunction

   task automatic check_flags();
      assert (weights_progd == mdl_progd[0]) else
         fail_now($sformatf("FAILED weights_progd: expected 0x%h, got 0x%h",
                            mdl_progd[0], weights_progd));
      assert (data_vec_progd == mdl_progd[1]) else
         fail_now($sformatf("FAILED data_vec_progd: expected 0x%h, got 0x%h",
                            mdl_progd[1], data_vec_progd));
   endtask

   task automatic write_word(input logic target, input data_t word);
      check_flags();  // flag must not rise early.
      arr_wghtbar_data  = target;
      mem_mngr_data     = word;
      mem_mngr_data_vld = 1'b1;
      store_word(target, word);
      @(negedge clk);
      mem_mngr_data_vld = 1'b0;
      check_flags();
   endtask

   task automatic start_compute(input int n);
      for (int k = 0; k < n; k++) begin
         comp_start = 1'b1;
         if (mdl_progd[0] && mdl_progd[1]) begin
            exp_sum.push_back(expected_dot());
            exp_due.push_back(cyc + LATENCY);
         end
         @(negedge clk);
      end
      comp_start = 1'b0;
   endtask

   task automatic drain_results();
      while (exp_sum.size() > 0) begin
         @(negedge clk);
      end
   endtask

   task automatic clear_vectors();
      clear_weights_n_data = 1'b1;
      wipe_model();
      @(negedge clk);
      clear_weights_n_data = 1'b0;
      check_flags();  // both flags back low.
   endtask

   task automatic load_vectors();
      int   pick;
      bit   early_done;
      logic target;
      early_done = 1'b0;
      while (!(mdl_progd[0] && mdl_progd[1])) begin
         pick = pick_range(0, 5);
         if (pick == 0) begin
            @(negedge clk);  // idle gap.
         end else if (pick == 1 && !early_done) begin
            start_compute(1);  // one vector still incomplete.
            early_done = 1'b1;
         end else begin
            if (mdl_progd[0]) begin
               target = 1'b1;
            end else if (mdl_progd[1]) begin
               target = 1'b0;
            end else begin
               target = (pick_range(0, 1) == 1);
            end
            write_word(target, random_word());
         end
      end
      repeat (pick_range(0, 3)) begin
         write_word(pick_range(0, 1) == 1, random_word());  // extras, dropped.
      end
   endtask

   // result checker, runs on every falling edge
   always @(negedge clk) begin
      if (!reset) begin
         if (data_out_vld) begin
            assert (exp_sum.size() > 0) else
               fail_now("data_out_vld pulsed although no compute was launched");
            assert (exp_due[0] == cyc) else
               fail_now($sformatf("result came at cycle %0d but was due at cycle %0d",
                                  cyc, exp_due[0]));
            assert (data_out == exp_sum[0]) else
               fail_now($sformatf("FAILED data_out: expected 0x%h, got 0x%h",
                                  exp_sum[0], data_out));
            void'(exp_sum.pop_front());
            void'(exp_due.pop_front());
         end else if (exp_due.size() > 0) begin
            assert (exp_due[0] != cyc) else
               fail_now("no data_out_vld in the cycle a result was due");
         end
      end
   end

   // bound protocol checks on the DUT
   always @(negedge clk) begin
      assert (dut.u_props.err_count == 0) else
         fail_now("a bound assertion on the DUT failed");
   end

   initial begin
      #(WATCHDOG_NS);
      fail_now("timeout, the simulation hung waiting for the DUT");
   end

   initial begin
      reset                 = 1'b1;
      mem_mngr_data         = '0;
      mem_mngr_data_vld     = 1'b0;
      svm_ctrl_part_num_dim = dim_t'(1);
      comp_start            = 1'b0;
      arr_wghtbar_data      = 1'b0;
      clear_weights_n_data  = 1'b0;
      mdl_dim               = 1;
      wipe_model();

      repeat (5) @(negedge clk);
      reset = 1'b0;

      check_flags();
      assert (data_out_vld == 1'b0) else
         fail_now($sformatf("FAILED data_out_vld: expected 0x0, got 0x%h", data_out_vld));
      assert (data_out == '0) else
         fail_now($sformatf("FAILED data_out: expected 0x0, got 0x%h", data_out));

      for (int r = 0; r < NUM_ROUNDS; r++) begin
         clear_vectors();
         mdl_dim               = pick_range(1, NUM_LANES);
         svm_ctrl_part_num_dim = dim_t'(mdl_dim);
         start_compute(1);  // nothing programmed yet.
         load_vectors();
         start_compute(1);
         drain_results();
         start_compute(pick_range(2, 6));
         drain_results();
      end

      if (dut.u_props.err_count == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         fail_now("a bound assertion on the DUT failed");
      end
   end

endmodule

// ==== svm_dot.f ====
+incdir+verilog
verilog/svm_dot_pkg.sv
verilog/svm_vec_if.sv
verilog/svm_vec_loader.sv
verilog/svm_mult_lane.sv
verilog/svm_adder_tree.sv
verilog/svm_dot_core.sv
verification/svm_dot_core_props.sv
verification/svm_dot_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=obj_dir/svm_dot_sim

verilator --binary --assert -f svm_dot.f --top-module svm_dot_core_tb -o svm_dot_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"$EXE" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

echo "simulation finished cleanly"
exit 0
